// ==== vit_pkg.sv ====
package vit_pkg;

    // trellis shape for K=3
    localparam int NUM_STATES = 4;              // 2^(K-1) states
    localparam int STATE_W    = 2;              // state = {newest bit, older bit}

    // frame layout
    localparam int FRAME_LEN  = 16;             // trellis steps per frame
    localparam int TAIL_LEN   = 2;              // zero flush bits, K-1
    localparam int DATA_W     = FRAME_LEN - TAIL_LEN;
    localparam int STEP_W     = 4;              // addresses FRAME_LEN steps

    // path metrics
    localparam int PM_W       = 6;              // 2 per step worst case, 32 fits
    localparam logic [PM_W-1:0] PM_MAX = '1;    // start value of unreachable states

    // generator taps, bit 2 is the current input bit
    localparam logic [2:0] GEN0 = 3'o7;         // first code bit
    localparam logic [2:0] GEN1 = 3'o5;         // second code bit

    // frame FSM encoding
    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_ACQ   = 2'd1;     // collecting symbol pairs
    localparam logic [1:0] ST_TRACE = 2'd2;     // walking survivors back
    localparam logic [1:0] ST_DONE  = 2'd3;

endpackage

// ==== vit_control.sv ====
`timescale 1ns/10ps

module vit_control
    import vit_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic i_start,       // one-cycle frame start
    input  logic i_sym_valid,   // symbol strobe from outside
    input  logic i_last,        // from step counter
    output logic o_clr,
    output logic o_cnt_up,
    output logic o_cnt_down,
    output logic o_en_acs,
    output logic o_en_tb,
    output logic o_busy,
    output logic o_done
);

logic [1:0] state;
logic [1:0] state_nxt;

always_ff @(posedge clk or negedge rst)
begin
    if (!rst)
    begin
        state  <= ST_IDLE;
        o_done <= 1'b0;
    end
    else
    begin
        state  <= state_nxt;
        o_done <= (state == ST_DONE);   // one cycle after trace ends
    end
end

always_comb
begin
    state_nxt = state;
    case (state)
        ST_IDLE:
            if (i_start)
                state_nxt = ST_ACQ;
        ST_ACQ:
            if (i_last)                 // 16th strobe, counter at top
                state_nxt = ST_TRACE;
        ST_TRACE:
            if (i_last)                 // step 0 read this cycle
                state_nxt = ST_DONE;
        default:
            state_nxt = ST_IDLE;        // done lasts a single cycle
    endcase
end

// block enables
assign o_clr      = (state == ST_IDLE) && i_start;
assign o_en_acs   = (state == ST_ACQ) && i_sym_valid;   // stray strobes elsewhere dropped
assign o_en_tb    = (state == ST_TRACE);
assign o_cnt_up   = o_en_acs;
assign o_cnt_down = o_en_tb;
assign o_busy     = (state != ST_IDLE);                 // drops as o_done rises

a_done_pulse: assert property (@(posedge clk) disable iff (!rst) o_done |=> !o_done);
a_en_excl:    assert property (@(posedge clk) disable iff (!rst) !(o_en_acs && o_en_tb));

endmodule

// ==== vit_step_counter.sv ====
`timescale 1ns/10ps

module vit_step_counter
    import vit_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              i_clr,    // frame start
    input  logic              i_up,     // acquire steps
    input  logic              i_down,   // traceback steps
    output logic [STEP_W-1:0] o_step,   // survivor memory address
    output logic              o_last
);

logic [STEP_W-1:0] step;

assign o_step = step;

// top going up, bottom going down
assign o_last = (i_up && step == STEP_W'(FRAME_LEN - 1)) || (i_down && step == '0);

always_ff @(posedge clk or negedge rst)
begin
    if (!rst)
        step <= '0;
    else if (i_clr)
        step <= '0;
    else if (!o_last)                   // hold at the turn, 15 is also first trace address
    begin
        if (i_up)
            step <= step + STEP_W'(1);
        else if (i_down)
            step <= step - STEP_W'(1);
    end
end

a_dir_excl: assert property (@(posedge clk) disable iff (!rst) !(i_up && i_down));

endmodule

// ==== vit_acs.sv ====
`timescale 1ns/10ps

module vit_acs
    import vit_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  i_clr,
    input  logic                  i_en,     // one trellis step
    input  logic [1:0]            i_sym,    // [1] first code bit, [0] second
    output logic [NUM_STATES-1:0] o_dec     // 1 = odd predecessor won
);

logic [PM_W-1:0] pm     [NUM_STATES];
logic [PM_W-1:0] pm_nxt [NUM_STATES];
logic [PM_W:0]   sum0   [NUM_STATES];      // via predecessor {ns[0],0}
logic [PM_W:0]   sum1   [NUM_STATES];      // via predecessor {ns[0],1}
logic [PM_W:0]   pm_sum [NUM_STATES];      // winner before saturation
logic            from_real [NUM_STATES];   // winner came from a reachable state

// encoder output pair for input u leaving state p
function automatic logic [1:0] branch_bits(input logic u, input logic [STATE_W-1:0] p);
    logic [2:0] r;
    r = {u, p};
    branch_bits = {^(r & GEN0), ^(r & GEN1)};
endfunction

function automatic logic [1:0] hamming(input logic [1:0] a, input logic [1:0] b);
    logic [1:0] x;
    x = a ^ b;
    hamming = {1'b0, x[1]} + {1'b0, x[0]};
endfunction

always_comb
begin
    logic [STATE_W-1:0] p0;
    logic [STATE_W-1:0] p1;
    logic               u;
    for (int ns = 0; ns < NUM_STATES; ns++)
    begin
        u  = ns[1];                         // bit that entered ns
        p0 = {ns[0], 1'b0};
        p1 = {ns[0], 1'b1};
        sum0[ns] = {1'b0, pm[p0]} + (PM_W+1)'(hamming(i_sym, branch_bits(u, p0)));
        sum1[ns] = {1'b0, pm[p1]} + (PM_W+1)'(hamming(i_sym, branch_bits(u, p1)));
        o_dec[ns]     = sum1[ns] < sum0[ns];   // tie keeps lower predecessor
        pm_sum[ns]    = o_dec[ns] ? sum1[ns] : sum0[ns];
        from_real[ns] = (o_dec[ns] ? pm[p1] : pm[p0]) != PM_MAX;
        pm_nxt[ns]    = pm_sum[ns][PM_W] ? PM_MAX : pm_sum[ns][PM_W-1:0];  // saturate
    end
end

// encoder starts in state 0, others unreachable
always_ff @(posedge clk or negedge rst)
begin
    if (!rst)
    begin
        for (int s = 0; s < NUM_STATES; s++)
            pm[s] <= (s == 0) ? '0 : PM_MAX;
    end
    else if (i_clr)
    begin
        for (int s = 0; s < NUM_STATES; s++)
            pm[s] <= (s == 0) ? '0 : PM_MAX;
    end
    else if (i_en)
    begin
        for (int s = 0; s < NUM_STATES; s++)
            pm[s] <= pm_nxt[s];
    end
end

// a real path never has to be clipped over a whole frame
for (genvar g = 0; g < NUM_STATES; g++)
begin : g_pm_chk
    a_pm_range: assert property (@(posedge clk) disable iff (!rst)
        i_en && from_real[g] |-> pm_sum[g] <= (PM_W+1)'(PM_MAX));
end

endmodule

// ==== vit_survivor_mem.sv ====
`timescale 1ns/10ps

module vit_survivor_mem
    import vit_pkg::*;
(
    input  logic                  clk,
    input  logic                  i_we,     // acquire step
    input  logic [STEP_W-1:0]     i_addr,   // trellis step
    input  logic [NUM_STATES-1:0] i_wdata,  // decisions from acs
    output logic [NUM_STATES-1:0] o_rdata   // decisions to traceback
);

// one row per trellis step
// each row holds one decision bit per state
logic [NUM_STATES-1:0] mem [FRAME_LEN];

always_ff @(posedge clk)
begin
    if (i_we)
        mem[i_addr] <= i_wdata;     // written while the step counter moves up
end

// read side is async
// traceback consumes the row in the same cycle
assign o_rdata = mem[i_addr];

endmodule

// ==== vit_traceback.sv ====
`timescale 1ns/10ps

module vit_traceback
    import vit_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  i_clr,    // frame start
    input  logic                  i_en,     // one backward step per cycle
    input  logic [NUM_STATES-1:0] i_dec,    // decisions for the current step
    output logic [STATE_W-1:0]    o_state,
    output logic [DATA_W-1:0]     o_data    // bit i was sent at step i
);

logic [STATE_W-1:0]   state;
logic [STATE_W-1:0]   state_prev;
logic [FRAME_LEN-1:0] bits;         // decoded bits, newest step shifted in first
logic                 en_q;

assign o_state = state;

// predecessor is {older bit, decision bit}
assign state_prev = {o_state[0], i_dec[o_state]};

always_ff @(posedge clk or negedge rst)
begin
    if (!rst)
    begin
        state <= '0;
        bits  <= '0;
        en_q  <= 1'b0;
    end
    else
    begin
        en_q <= i_en;
        if (i_clr)
        begin
            state <= '0;            // zero tail ends in state 0
            bits  <= '0;
        end
        else if (i_en)
        begin
            state <= state_prev;
            bits  <= {bits[FRAME_LEN-2:0], state[STATE_W-1]};  // high bit is the input bit
        end
    end
end

// capture when traceback ends
// tail bits in bits[15:14] dropped
always_ff @(posedge clk)
begin
    if (en_q && !i_en)
        o_data <= bits[DATA_W-1:0];
end

endmodule

// ==== vit_top.sv ====
`timescale 1ns/10ps

module vit_top
    import vit_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              i_start,
    input  logic              i_sym_valid,
    input  logic [1:0]        i_sym,        // {first, second} code bit
    output logic [DATA_W-1:0] o_data,
    output logic              o_done,       // 18 cycles after last symbol strobe
    output logic              o_busy
);

logic                  clr;
logic                  cnt_up;
logic                  cnt_down;
logic                  en_acs;
logic                  en_tb;
logic                  last;
logic [STEP_W-1:0]     step;
logic [NUM_STATES-1:0] dec_wr;      // acs to memory
logic [NUM_STATES-1:0] dec_rd;      // memory to traceback

vit_control u_ctrl (
    .clk         (clk),
    .rst         (rst),
    .i_start     (i_start),
    .i_sym_valid (i_sym_valid),
    .i_last      (last),
    .o_clr       (clr),
    .o_cnt_up    (cnt_up),
    .o_cnt_down  (cnt_down),
    .o_en_acs    (en_acs),
    .o_en_tb     (en_tb),
    .o_busy      (o_busy),
    .o_done      (o_done)
);

vit_step_counter u_cnt (
    .clk    (clk),
    .rst    (rst),
    .i_clr  (clr),
    .i_up   (cnt_up),
    .i_down (cnt_down),
    .o_step (step),
    .o_last (last)
);

vit_acs u_acs (
    .clk   (clk),
    .rst   (rst),
    .i_clr (clr),
    .i_en  (en_acs),
    .i_sym (i_sym),
    .o_dec (dec_wr)
);

vit_survivor_mem u_mem (
    .clk     (clk),
    .i_we    (en_acs),
    .i_addr  (step),            // same address for write and read
    .i_wdata (dec_wr),
    .o_rdata (dec_rd)
);

vit_traceback u_tb (
    .clk     (clk),
    .rst     (rst),
    .i_clr   (clr),
    .i_en    (en_tb),
    .i_dec   (dec_rd),
    .o_state (),                // debug view only
    .o_data  (o_data)
);

endmodule

// ==== tb_clk_gen.sv ====
`timescale 1ns/10ps

module tb_clk_gen (
    output logic clk,
    output logic rst
);

initial
begin
    clk = 1'b0;
    forever #5 clk = ~clk;      // 10 ns period
end

// active low reset for 16 cycles, released just after an edge
initial
begin
    rst = 1'b0;
    repeat (16) @(posedge clk);
    #1 rst = 1'b1;
end

endmodule

// ==== tb_checker.sv ====
`timescale 1ns/10ps

module tb_checker
    import vit_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              i_done,
    input  logic              i_busy,
    input  logic [DATA_W-1:0] i_data,
    input  logic              i_sym_last    // 16th strobe of the frame
);

string             exp_name;
logic [DATA_W-1:0] exp_word;
int                mismatches;
int                failures;
int                since_last;      // cycles since the 16th strobe
bit                armed;           // frame in flight
logic              busy_q;

initial
begin
    exp_name   = "none";
    exp_word   = '0;
    mismatches = 0;
    failures   = 0;
    since_last = 0;
    armed      = 1'b0;
    busy_q     = 1'b0;
end

task automatic expect_frame(input string name, input logic [DATA_W-1:0] word);
    exp_name = name;
    exp_word = word;
endtask

task automatic note_failure(input string msg);
    failures++;
    $display("ERROR %s", msg);
endtask

function automatic int error_total();
    return mismatches + failures;
endfunction

task automatic print_summary();
    $display("error counts: %0d mismatches, %0d other failures", mismatches, failures);
endtask

// mid-cycle sampling, everything settled
always @(negedge clk)
begin
    if (!rst)
    begin
        if (i_done || i_busy)
            note_failure("o_done or o_busy high while in reset");
        armed = 1'b0;
    end
    else
    begin
        if (armed)
            since_last++;
        if (i_sym_last)
        begin
            armed      = 1'b1;
            since_last = 0;
        end
        if (i_done && !armed)
            note_failure("o_done pulsed with no frame in flight");
        else if (i_done)
        begin
            if (i_data !== exp_word)
            begin
                mismatches++;
                $display("MISMATCH %s: expected %h, actual %h", exp_name, exp_word, i_data);
            end
            if (since_last != FRAME_LEN + 2)
                note_failure($sformatf("%s: o_done came %0d cycles after the last strobe, not %0d",
                                       exp_name, since_last, FRAME_LEN + 2));
            if (i_busy || !busy_q)      // busy must drop exactly here
                note_failure($sformatf("%s: o_busy did not fall with o_done", exp_name));
            armed = 1'b0;
        end
        busy_q = i_busy;
    end
end

endmodule

// ==== tb_top.sv ====
`timescale 1ns/10ps

module tb_top
    import vit_pkg::*;
();

logic              clk;
logic              rst;
logic              start;
logic              sym_valid;
logic [1:0]        sym;
logic [DATA_W-1:0] data;
logic              done;
logic              busy;
logic              sym_last;        // tells the checker where the frame ends
bit                abort;

tb_clk_gen clkgen0 (.clk(clk), .rst(rst));

vit_top dut0 (
    .clk         (clk),
    .rst         (rst),
    .i_start     (start),
    .i_sym_valid (sym_valid),
    .i_sym       (sym),
    .o_data      (data),
    .o_done      (done),
    .o_busy      (busy)
);

tb_checker chk0 (
    .clk        (clk),
    .rst        (rst),
    .i_done     (done),
    .i_busy     (busy),
    .i_data     (data),
    .i_sym_last (sym_last)
);

// rate 1/2 encoder over payload and zero tail
// first transmitted code bit lands in [31]
function automatic logic [2*FRAME_LEN-1:0] encode_frame(input logic [DATA_W-1:0] payload);
    logic [2*FRAME_LEN-1:0] code;
    logic [2:0]             r;
    logic                   u;
    logic                   d1;
    logic                   d2;
    code = '0;
    d1   = 1'b0;
    d2   = 1'b0;
    for (int s = 0; s < FRAME_LEN; s++)
    begin
        u = (s < DATA_W) ? payload[s] : 1'b0;      // payload bit s sent at step s
        r = {u, d1, d2};
        code[2*FRAME_LEN-1-2*s] = ^(r & GEN0);
        code[2*FRAME_LEN-2-2*s] = ^(r & GEN1);
        d2 = d1;
        d1 = u;
    end
    return code;
endfunction

task automatic next_cycle();
    @(posedge clk);
    #1;                             // drive and look 1 ns after the edge
endtask

task automatic wait_reset_release();
    int n;
    n = 0;
    while (rst !== 1'b1 && n < 100)
    begin
        @(posedge clk);
        n++;
    end
    if (rst !== 1'b1)
    begin
        chk0.note_failure("reset was never released");
        abort = 1'b1;
    end
endtask

task automatic run_frame(input string name, input logic [DATA_W-1:0] payload,
                         input logic [2*FRAME_LEN-1:0] mask,
                         input logic [DATA_W-1:0] expected,
                         input bit rand_gap, input int gap, input bit poke);
    logic [2*FRAME_LEN-1:0] rx;
    int                     g;
    int                     n;
    rx = encode_frame(payload) ^ mask;          // channel errors
    chk0.expect_frame(name, expected);
    start = 1'b1;
    next_cycle();
    start = 1'b0;
    for (int s = 0; s < FRAME_LEN; s++)
    begin
        sym_valid = 1'b1;
        sym       = {rx[2*FRAME_LEN-1-2*s], rx[2*FRAME_LEN-2-2*s]};
        sym_last  = (s == FRAME_LEN - 1);
        next_cycle();
        sym_valid = 1'b0;
        sym_last  = 1'b0;
        if (s < FRAME_LEN - 1)
        begin
            g = rand_gap ? int'($urandom % 4) : gap;
            repeat (g) next_cycle();
        end
    end
    if (poke)
    begin
        // stray start and strobe while the DUT walks back
        repeat (2) next_cycle();
        start = 1'b1;
        next_cycle();
        start = 1'b0;
        repeat (2) next_cycle();
        sym_valid = 1'b1;
        sym       = 2'b11;
        next_cycle();
        sym_valid = 1'b0;
    end
    n = 0;
    while (!done && n < 4*FRAME_LEN)
    begin
        next_cycle();
        n++;
    end
    if (!done)
    begin
        chk0.note_failure($sformatf("%s: timed out waiting for o_done", name));
        abort = 1'b1;
    end
    else
        next_cycle();               // step past the done cycle
endtask

initial
begin
    int                     fd;
    int                     n;
    int                     tests_run;
    string                  line;
    string                  name;
    string                  gap_txt;
    logic [DATA_W-1:0]      payload;
    logic [2*FRAME_LEN-1:0] mask;
    logic [DATA_W-1:0]      expected;
    start     = 1'b0;
    sym_valid = 1'b0;
    sym       = 2'b00;
    sym_last  = 1'b0;
    abort     = 1'b0;
    tests_run = 0;
    fd        = 0;
    void'($urandom(2));
    wait_reset_release();
    if (!abort)
    begin
        fd = $fopen("vit_tests.dat", "r");
        if (fd == 0)
        begin
            chk0.note_failure("could not open vit_tests.dat");
            abort = 1'b1;
        end
    end
    next_cycle();
    if (!abort)
    begin
        sym_valid = 1'b1;           // stray strobe in idle, the first frame must not notice
        sym       = 2'b01;
        next_cycle();
        sym_valid = 1'b0;
        repeat (3*FRAME_LEN) next_cycle();     // quiet window where the checker flags any o_done
    end
    while (!abort && fd != 0 && !$feof(fd))
    begin
        n = $fgets(line, fd);
        if (n > 0 && $sscanf(line, "%s %h %h %h %s", name, payload, mask, expected,
                             gap_txt) == 5)
        begin
            run_frame(name, payload, mask, expected, gap_txt == "random", gap_txt.atoi(),
                      tests_run % 2 == 1);     // every other frame gets stray pulses
            tests_run++;
        end
    end
    if (fd != 0)
        $fclose(fd);
    if (!abort && tests_run == 0)
        chk0.note_failure("no tests found in vit_tests.dat");
    chk0.print_summary();
    if (chk0.error_total() == 0)
        $display("TB PASSED");
    else
        $display("TB FAILED");
    $finish;
end

endmodule

// ==== vit_tests.dat ====
# test name, payload hex, error mask hex, expected word hex, gap
# mask bit 31 flips the first transmitted code bit; gap is idle cycles or random
zeros       0000 00000000 0000 0
ones        3fff 00000000 3fff 0
alt_a       1555 00000000 1555 0
alt_b       2aaa 00000000 2aaa 0
mixed       2c5b 00000000 2c5b 0
err_first   1234 80000000 1234 0
err_second  0fff 40000000 0fff 0
err_mid     3a5c 00010000 3a5c 0
err_last    1234 00000001 1234 0
two_err_a   1b6d 80004000 1b6d 0
two_err_b   2e71 00400004 2e71 0
two_err_c   0001 00100001 0001 0
gap_fixed   2c5b 00000000 2c5b 3
gap_big     3333 00000000 3333 7
gap_rand    1e3c 00800000 1e3c random
gap_rand2   0ace 00000000 0ace random

// ==== tb.f ====
vit_pkg.sv
vit_control.sv
vit_step_counter.sv
vit_acs.sv
vit_survivor_mem.sv
vit_traceback.sv
vit_top.sv
tb_clk_gen.sv
tb_checker.sv
tb_top.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        ?= tb_top
FILELIST   ?= tb.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
BUILD_OPTS ?= --binary --timing --assert -j 0
LINT_OPTS  ?= --lint-only --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_OPTS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(BUILD_OPTS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "TB PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
